/* verilog/nco_pkg.sv */
// nco definitions: angle and waveform widths, quarter-wave table contents, control opcodes
`default_nettype none

package nco_pkg;

   localparam int NBA          = 22;                // angle bits, one full turn
   localparam int NBO          = 18;                // signed waveform bits
   localparam int TABLE_ADDR_W = 10;                // quarter-wave index bits
   localparam int TABLE_N      = 1 << TABLE_ADDR_W; // entries per quarter
   localparam real HALF_PI     = 1.5707963267948966;

   // control opcode; anything but op_nop is a strobe
   typedef enum logic [1:0] {
      op_nop       = 2'd0,
      op_set_freq  = 2'd1,
      op_set_phase = 2'd2,
      op_clear     = 2'd3
   } ctl_op_t;

   // rounded quarter-wave magnitude, zero past the last entry
   function automatic int coarse_val(input int idx, input int nbo);
      real amp;
      amp = real'((1 << (nbo - 1)) - 1);           // full scale minus one
      if (idx >= TABLE_N) begin
         return 0;
      end
      return $rtoi(amp * $cos(HALF_PI * idx / TABLE_N) + 0.5);
   endfunction

   // coarse in the upper nbo-1 bits, slope to the next entry in the low nbo-10 bits
   function automatic logic [63:0] table_word(input int idx, input int nbo);
      logic [63:0] coarse;
      logic [63:0] slope;
      coarse = 64'(coarse_val(idx, nbo));
      slope  = 64'(coarse_val(idx, nbo) - coarse_val(idx + 1, nbo));
      return (coarse << (nbo - 10)) | (slope & ((64'd1 << (nbo - 10)) - 64'd1));
   endfunction

endpackage

`default_nettype wire

/* verilog/ddc_pkg.sv */
// down-converter definitions: sample width and type, stage latencies
`default_nettype none

package ddc_pkg;

   localparam int SW = 16;                          // input and output sample bits

   typedef logic signed [SW-1:0] sample_t;          // real in, I and Q out

   // latencies in clocks
   localparam int ACC_LAT = 1;                      // phase_accum register stage
   localparam int NCO_LAT = 7;                      // angle to waveform, rom included
   localparam int MIX_LAT = 2;                      // product stage + output stage

   // in_valid to out_valid across the whole chain
   localparam int TOP_LAT = ACC_LAT + NCO_LAT + MIX_LAT;

endpackage

`default_nettype wire

/* verilog/mix_if.sv */
// mixer input bundle: aligned sample and strobe from the accumulator, cosine and sine
`timescale 1ns/1ps
`default_nettype none

interface mix_if #(
   parameter int nbo = 18,
   parameter int sw  = 16
);

   logic signed [sw-1:0]  sample;                   // sample registered with its angles
   logic                  valid;                    // strobe for sample
   logic signed [nbo-1:0] cos_v;                    // lags sample by the nco latency
   logic signed [nbo-1:0] sin_v;                    // same lag as cos_v

   modport accum (output sample, output valid);

   modport mixer (input sample, input valid, input cos_v, input sin_v);

endinterface

`default_nettype wire

/* verilog/phase_accum.sv */
// phase accumulator: control decode, per-sample cosine and sine angles, sample register
`timescale 1ns/1ps
`default_nettype none

module phase_accum #(
   parameter int nba = 22,
   parameter int sw  = 16
) (
   input  logic             c,
   input  logic             rst_n,
   input  nco_pkg::ctl_op_t ctl_op,
   input  logic [nba-1:0]   ctl_data,
   input  logic             in_valid,
   input  ddc_pkg::sample_t in_sample,
   output logic [nba-1:0]   cos_angle,
   output logic [nba-1:0]   sin_angle,
   mix_if.accum             mix
);

   import nco_pkg::*;

   localparam logic [nba-1:0] quarter = {2'b01, {(nba - 2){1'b0}}}; // a quarter turn

   logic [nba-1:0]       freq;                      // angle step per accepted sample
   logic [nba-1:0]       phase;                     // static offset on top of acc
   logic [nba-1:0]       acc;                       // running phase
   logic [nba-1:0]       angle;                     // cosine angle of this cycle's sample
   logic signed [sw-1:0] smp_r;                     // sample held with its angles

   assign angle = acc + phase;                      // wraps mod one turn

   // control registers; a write is seen by samples from the next cycle on
   always_ff @(posedge c or negedge rst_n) begin
      if (!rst_n) begin
         freq  <= '0;
         phase <= '0;
      end else begin
         case (ctl_op)
            op_set_freq:  freq  <= ctl_data;
            op_set_phase: phase <= ctl_data;
            default:      ;                         // nop, clear handled below
         endcase
      end
   end

   // accumulator steps only on accepted samples
   always_ff @(posedge c or negedge rst_n) begin
      if (!rst_n) begin
         acc <= '0;
      end else if (ctl_op == op_clear) begin
         acc <= '0;                                 // sample this cycle keeps old acc
      end else if (in_valid) begin
         acc <= acc + freq;                         // old freq, as for the angle
      end
   end

   always_ff @(posedge c or negedge rst_n) begin
      if (!rst_n) begin
         mix.valid <= 1'b0;
      end else begin
         mix.valid <= in_valid;                     // one clock, same as the angles
      end
   end

   // payload only loads on a valid sample
   always_ff @(posedge c) begin
      if (in_valid) begin
         cos_angle <= angle;
         sin_angle <= angle - quarter;              // sin(x) = cos(x - quarter turn)
         smp_r     <= in_sample;
      end
   end

   assign mix.sample = smp_r;

endmodule

`default_nettype wire

/* verilog/cos_table_rom.sv */
// quarter-wave cosine table, coarse value and slope per entry, two registered read ports
`timescale 1ns/1ps
`default_nettype none

module cos_table_rom #(
   parameter int nbo = 18
) (
   input  logic                             c,
   input  logic [nco_pkg::TABLE_ADDR_W-1:0] addr_a,
   input  logic [nco_pkg::TABLE_ADDR_W-1:0] addr_b,
   output logic [2*nbo-12:0]                data_a,
   output logic [2*nbo-12:0]                data_b
);

   import nco_pkg::*;

   localparam int dw = 2 * nbo - 11;                // coarse nbo-1 plus slope nbo-10

   wire  [dw-1:0]           rom [TABLE_N];          // constant contents
   logic [TABLE_ADDR_W-1:0] addr_a_r;               // address stage, port a
   logic [TABLE_ADDR_W-1:0] addr_b_r;               // address stage, port b

   // every word evaluated at elaboration
   for (genvar i = 0; i < TABLE_N; i++) begin : g_word
      localparam logic [dw-1:0] word = dw'(table_word(i, nbo));
      assign rom[i] = word;
   end

   // address reg then data reg, block-ram style
   always_ff @(posedge c) begin
      addr_a_r <= addr_a;
      addr_b_r <= addr_b;
      data_a   <= rom[addr_a_r];
      data_b   <= rom[addr_b_r];
   end

endmodule

`default_nettype wire

/* verilog/cosine_int.sv */
// interpolating cosine: quadrant fold, table lookup, slope correction, sign restore in 7 clocks
`timescale 1ns/1ps
`default_nettype none

module cosine_int #(
   parameter int nba = 22,                          // angle bits, all below the index interpolated
   parameter int nbo = 18                           // output bits
) (
   input  logic                             c,
   input  logic                             rst_n,
   input  logic [nba-1:0]                   a,
   input  logic [2*nbo-12:0]                rom_d,
   output logic [nco_pkg::TABLE_ADDR_W-1:0] rom_a,
   output logic signed [nbo-1:0]            o
);

   import nco_pkg::*;

   localparam int nbp = nba - 2 - TABLE_ADDR_W;     // bits into the interpolator
   localparam int nbm = nbo - 10;                   // slope bits
   localparam int pw  = nbo + nbp - 1;              // magnitude before the final shift

   logic [5:0]          sign;                       // sign follows the data down 6 stages
   logic [nba-3:0]      a_fold;                     // angle folded into the first quadrant
   logic [nbp-1:0]      alow_0;                     // stages 0, 1 wait for the rom
   logic [nbp-1:0]      alow_1;
   logic [nbp-1:0]      alow_2;                     // stages 2..5 map onto a dsp slice
   logic [nbp-1:0]      alow_3;
   logic [nbo-2:0]      coarse_2;
   logic [nbo-2:0]      coarse_3;
   logic [nbo-2:0]      coarse_4;
   logic [nbm-1:0]      fine_2;
   logic [nbm-1:0]      fine_3;
   logic [nbp+nbm-1:0]  p_4;                        // slope times fraction
   logic [pw-1:0]       round_c;                    // coarse scaled up, half lsb added
   logic [pw-1:0]       p_5;                        // interpolated magnitude
   logic signed [pw:0]  s_5;                        // with sign applied

   // second and fourth quadrants run the table backwards
   assign a_fold  = a[nba-2] ? ~a[nba-3:0] : a[nba-3:0];
   assign rom_a   = a_fold[nba-3:nbp];              // index bits
   assign round_c = {coarse_4, 1'b1} << (nbp - 1);  // rounding for the final drop of nbp bits
   assign s_5     = sign[5] ? -$signed({1'b0, p_5}) : $signed({1'b0, p_5});

   // cos is negative in the middle two quadrants
   always_ff @(posedge c or negedge rst_n) begin
      if (!rst_n) begin
         sign <= '0;
      end else begin
         sign <= {sign[4:0], a[nba-1] ^ a[nba-2]};
      end
   end

   always_ff @(posedge c) begin
      alow_0   <= a_fold[nbp-1:0];
      alow_1   <= alow_0;

      alow_2   <= alow_1;                           // rom data lines up here
      fine_2   <= rom_d[nbm-1:0];
      coarse_2 <= rom_d[2*nbo-12:nbm];

      alow_3   <= alow_2;                           // dsp input regs
      fine_3   <= fine_2;
      coarse_3 <= coarse_2;

      p_4      <= fine_3 * alow_3;                  // dsp multiply
      coarse_4 <= coarse_3;

      p_5      <= round_c - pw'(p_4);               // slope is coarse minus next, so subtract

      o        <= s_5[pw:nbp];                      // arithmetic shift down to nbo bits
   end

endmodule

`default_nettype wire

/* verilog/quad_mixer.sv */
// quadrature mixer: aligns samples to the nco outputs and forms I and Q
`timescale 1ns/1ps
`default_nettype none

module quad_mixer #(
   parameter int nbo = 18,
   parameter int sw  = 16
) (
   input  logic             c,
   input  logic             rst_n,
   mix_if.mixer             mix,
   output logic             out_valid,
   output ddc_pkg::sample_t out_i,
   output ddc_pkg::sample_t out_q
);

   import ddc_pkg::*;

   localparam int pdw = sw + nbo;                   // full product width
   localparam int vln = NCO_LAT + MIX_LAT;          // strobe shift length

   logic signed [sw-1:0]  smp_d [NCO_LAT];          // sample delay, matches nco latency
   logic [vln-1:0]        vld_sr;                   // strobe through delay and mix stages
   logic signed [pdw-1:0] prod_i;
   logic signed [pdw-1:0] prod_q;

   // strobe pipeline is the only reset state here
   always_ff @(posedge c or negedge rst_n) begin
      if (!rst_n) begin
         vld_sr <= '0;
      end else begin
         vld_sr <= {vld_sr[vln-2:0], mix.valid};
      end
   end

   assign out_valid = vld_sr[vln-1];

   always_ff @(posedge c) begin
      smp_d[0] <= mix.sample;
      for (int k = 1; k < NCO_LAT; k++) begin
         smp_d[k] <= smp_d[k-1];
      end
   end

   // smp_d tail and cos_v/sin_v now belong to the same sample
   always_ff @(posedge c) begin
      prod_i <= smp_d[NCO_LAT-1] * mix.cos_v;
      prod_q <= -(smp_d[NCO_LAT-1] * mix.sin_v);    // Q = -x*sin
      out_i  <= prod_i[pdw-2:nbo-1];                // >>> nbo-1, keep sw bits
      out_q  <= prod_q[pdw-2:nbo-1];
   end

endmodule

`default_nettype wire

/* verilog/ddc_top.sv */
// down-converter front end: phase accumulator, dual cosine generator on a shared table, mixer
`timescale 1ns/1ps
`default_nettype none

module ddc_top #(
   parameter int nba = nco_pkg::NBA,
   parameter int nbo = nco_pkg::NBO,
   parameter int sw  = ddc_pkg::SW
) (
   input  logic             c,
   input  logic             rst_n,
   input  nco_pkg::ctl_op_t ctl_op,
   input  logic [nba-1:0]   ctl_data,
   input  logic             in_valid,
   input  ddc_pkg::sample_t in_sample,
   output logic             out_valid,
   output ddc_pkg::sample_t out_i,
   output ddc_pkg::sample_t out_q
);

   import nco_pkg::*;

   logic [nba-1:0]          cos_angle;              // angle for the I path
   logic [nba-1:0]          sin_angle;              // cos_angle minus a quarter turn
   logic [TABLE_ADDR_W-1:0] rom_a_cos;
   logic [TABLE_ADDR_W-1:0] rom_a_sin;
   logic [2*nbo-12:0]       rom_d_cos;
   logic [2*nbo-12:0]       rom_d_sin;

   mix_if #(.nbo(nbo), .sw(sw)) mix ();

   phase_accum #(.nba(nba), .sw(sw)) u_accum (
      .c         (c),
      .rst_n     (rst_n),
      .ctl_op    (ctl_op),
      .ctl_data  (ctl_data),
      .in_valid  (in_valid),
      .in_sample (in_sample),
      .cos_angle (cos_angle),
      .sin_angle (sin_angle),
      .mix       (mix.accum)
   );

   // port a serves cosine, port b sine
   cos_table_rom #(.nbo(nbo)) u_rom (
      .c      (c),
      .addr_a (rom_a_cos),
      .addr_b (rom_a_sin),
      .data_a (rom_d_cos),
      .data_b (rom_d_sin)
   );

   cosine_int #(.nba(nba), .nbo(nbo)) cos_path (
      .c     (c),
      .rst_n (rst_n),
      .a     (cos_angle),
      .rom_d (rom_d_cos),
      .rom_a (rom_a_cos),
      .o     (mix.cos_v)                            // straight into the mixer bundle
   );

   cosine_int #(.nba(nba), .nbo(nbo)) sin_path (
      .c     (c),
      .rst_n (rst_n),
      .a     (sin_angle),
      .rom_d (rom_d_sin),
      .rom_a (rom_a_sin),
      .o     (mix.sin_v)
   );

   quad_mixer #(.nbo(nbo), .sw(sw)) u_mixer (
      .c         (c),
      .rst_n     (rst_n),
      .mix       (mix.mixer),
      .out_valid (out_valid),
      .out_i     (out_i),
      .out_q     (out_q)
   );

endmodule

`default_nettype wire

/* tests/ddc_chk.sv */
// ddc_top checker for quiet reset, fixed in-to-out latency and known values on the ports
`timescale 1ns/1ps
`default_nettype none

module ddc_chk (
   input logic             c,
   input logic             rst_n,
   input nco_pkg::ctl_op_t ctl_op,
   input logic             in_valid,
   input logic             out_valid,
   input ddc_pkg::sample_t out_i,
   input ddc_pkg::sample_t out_q
);

   import ddc_pkg::*;

   int n_fail = 0;                                  // failed assertions so far

   // strobe pipeline held clear by reset
   a_idle_in_reset: assert property (@(posedge c) !rst_n |-> !out_valid)
      else begin
         $error("out_valid high while rst_n low");
         n_fail++;
      end

   a_latency: assert property (@(posedge c) disable iff (!rst_n)
                               out_valid == $past(in_valid, TOP_LAT))
      else begin
         $error("out_valid does not follow in_valid by the pipeline latency");
         n_fail++;
      end

   a_op_known: assert property (@(posedge c) disable iff (!rst_n) !$isunknown(ctl_op))
      else begin
         $error("ctl_op unknown after reset");
         n_fail++;
      end

   a_out_known: assert property (@(posedge c) disable iff (!rst_n)
                                 out_valid |-> !$isunknown({out_i, out_q}))
      else begin
         $error("out_i or out_q unknown with out_valid high");
         n_fail++;
      end

endmodule

bind ddc_top ddc_chk u_chk (
   .c         (c),
   .rst_n     (rst_n),
   .ctl_op    (ctl_op),
   .in_valid  (in_valid),
   .out_valid (out_valid),
   .out_i     (out_i),
   .out_q     (out_q)
);

`default_nettype wire

/* tests/ddc_tb.sv */
// down-converter testbench with a bit-exact I/Q model, an output monitor and directed tests
`timescale 1ns/1ps
`default_nettype none

module ddc_tb;

   import nco_pkg::*;
   import ddc_pkg::*;

   localparam int nba = NBA;
   localparam int nbo = NBO;
   localparam int nbp = nba - 2 - TABLE_ADDR_W;     // interpolated angle bits
   localparam int nbm = nbo - 10;                   // slope bits in a table word
   localparam logic [nba-1:0] quarter = {2'b01, {(nba - 2){1'b0}}};
   localparam logic [nba-1:0] half    = {2'b10, {(nba - 2){1'b0}}};
   localparam logic [nba-1:0] three_q = {2'b11, {(nba - 2){1'b0}}};
   localparam sample_t full_pos = {1'b0, {(SW - 1){1'b1}}};
   localparam sample_t full_neg = {1'b1, {(SW - 1){1'b0}}};

   logic           c;
   logic           rst_n;
   ctl_op_t        ctl_op;
   logic [nba-1:0] ctl_data;
   logic           in_valid;
   sample_t        in_sample;
   logic           out_valid;
   sample_t        out_i;
   sample_t        out_q;

   integer         seed;
   int             cyc;                             // rising edges so far
   int             n_in;
   int             n_out;                           // strobes seen on out_valid
   logic [nba-1:0] m_freq;                          // model copies of the control state
   logic [nba-1:0] m_phase;
   logic [nba-1:0] m_acc;
   sample_t        exp_i_q [$];
   sample_t        exp_q_q [$];
   int             exp_cyc_q [$];                   // cycle at which each result is due

   ddc_top #(.nba(nba), .nbo(nbo), .sw(SW)) uut (
      .c (c), .rst_n (rst_n), .ctl_op (ctl_op), .ctl_data (ctl_data),
      .in_valid (in_valid), .in_sample (in_sample),
      .out_valid (out_valid), .out_i (out_i), .out_q (out_q)
   );

   always #10 c = ~c;                               // 20 ns period

   always @(posedge c) cyc <= cyc + 1;

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation finished: FAIL");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_sample(input string what, input sample_t got, input sample_t exp);
      if (got !== exp) begin
         abort_run($sformatf("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp));
      end
   endtask

   task automatic check_strobe(input logic got, input logic exp);
      if (got !== exp) begin
         abort_run($sformatf("Fail at %0t: out_valid is %b, expected %b", $time, got, exp));
      end
   endtask

   // quarter-wave lookup with slope interpolation and sign from the table rules
   function automatic logic signed [nbo-1:0] cos_model(input logic [nba-1:0] a);
      logic           neg;
      logic [nba-3:0] fold;
      logic [63:0]    w;
      longint         coarse;
      longint         slope;
      longint         frac;
      longint         mag;
      neg    = a[nba-1] ^ a[nba-2];                 // negative in quadrants two and three
      fold   = a[nba-2] ? ~a[nba-3:0] : a[nba-3:0]; // mirror onto the first quadrant
      w      = table_word(int'(fold[nba-3:nbp]), nbo);
      coarse = longint'(w >> nbm) & ((longint'(1) << (nbo - 1)) - 1);
      slope  = longint'(w) & ((longint'(1) << nbm) - 1);
      frac   = longint'(fold[nbp-1:0]);
      mag    = (coarse << nbp) + (longint'(1) << (nbp - 1)) - slope * frac;
      if (neg) begin
         mag = -mag;
      end
      return nbo'(mag >>> nbp);                     // floor shift back to nbo bits
   endfunction

   function automatic sample_t mix_model(input sample_t x, input logic signed [nbo-1:0] w,
                                         input logic neg);
      longint p;
      p = longint'(x) * longint'(w);
      if (neg) begin
         p = -p;                                    // Q takes minus x times sine
      end
      return SW'(p >>> (nbo - 1));
   endfunction

   // drive the inputs on one falling edge and step the model as the next rising edge will
   task automatic drive_cycle(input ctl_op_t op, input logic [nba-1:0] d, input logic v,
                              input sample_t x);
      logic [nba-1:0] ang;
      @(negedge c);
      ctl_op    = op;
      ctl_data  = d;
      in_valid  = v;
      in_sample = x;
      if (v) begin
         ang = m_acc + m_phase;                     // old control values for this sample
         exp_i_q.push_back(mix_model(x, cos_model(ang), 1'b0));
         exp_q_q.push_back(mix_model(x, cos_model(ang - quarter), 1'b1));
         exp_cyc_q.push_back(cyc + TOP_LAT);
         n_in++;
      end
      if (op == op_clear) begin
         m_acc = '0;
      end else if (v) begin
         m_acc = m_acc + m_freq;
      end
      if (op == op_set_freq) begin
         m_freq = d;
      end
      if (op == op_set_phase) begin
         m_phase = d;
      end
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (exp_cyc_q.size() != 0) begin
         drive_cycle(op_nop, '0, 1'b0, '0);
         n++;
         if (n > 4 * TOP_LAT) begin
            abort_run("timeout while waiting for the pending outputs");
         end
      end
      repeat (4) drive_cycle(op_nop, '0, 1'b0, '0); // idle tail so the monitor can flag strays
   endtask

   // every result is due at a known cycle and any other strobe is an error
   always @(negedge c) begin : watch_outputs
      logic due;
      if (cyc > 0) begin
         if (uut.u_chk.n_fail != 0) begin
            abort_run("an assertion in the bound checker failed");
         end
         if (out_valid === 1'b1) begin
            n_out++;                                // counted from the DUT strobe
         end
         due = (exp_cyc_q.size() != 0) && (exp_cyc_q[0] == cyc);
         check_strobe(out_valid, due);
         if (due) begin
            void'(exp_cyc_q.pop_front());
            check_sample("out_i", out_i, exp_i_q.pop_front());
            check_sample("out_q", out_q, exp_q_q.pop_front());
         end
      end
   end

   task automatic test_reset_idle();
      repeat (40) begin
         drive_cycle(op_nop, '0, 1'b0, '0);
         check_strobe(out_valid, 1'b0);
      end
   endtask

   task automatic test_fixed_phase();
      logic [nba-1:0] ph [8];
      ph[0] = '0;
      ph[1] = quarter;
      ph[2] = half;
      ph[3] = three_q;
      ph[4] = nba'(32'h0005_a3c7);                  // one odd angle per quadrant
      ph[5] = quarter + nba'(32'h0002_e95d);
      ph[6] = half + nba'(32'h0003_7d13);
      ph[7] = three_q + nba'(32'h0000_1f0b);
      drive_cycle(op_set_freq, '0, 1'b0, '0);
      drive_cycle(op_clear, '0, 1'b0, '0);
      for (int k = 0; k < 8; k++) begin
         drive_cycle(op_set_phase, ph[k], 1'b0, '0);
         drive_cycle(op_nop, '0, 1'b1, full_pos);
         drive_cycle(op_nop, '0, 1'b1, full_neg);
      end
      wait_drain();
   endtask

   task automatic test_sweep();
      drive_cycle(op_set_freq, nba'($random(seed)), 1'b0, '0);
      for (int k = 0; k < 200; k++) begin
         if (k == 120) begin
            drive_cycle(op_set_freq, nba'($random(seed)), 1'b1, SW'($random(seed)));
         end else begin
            drive_cycle(op_nop, '0, 1'b1, SW'($random(seed)));
         end
      end
      wait_drain();
   endtask

   task automatic test_gapped();
      int in0;
      int out0;
      in0  = n_in;
      out0 = n_out;
      drive_cycle(op_set_freq, nba'($random(seed)), 1'b0, '0);
      for (int k = 0; k < 300; k++) begin
         drive_cycle(op_nop, '0, ($random(seed) & 3) != 0, SW'($random(seed)));
      end
      wait_drain();
      if ((n_out - out0) != (n_in - in0)) begin
         abort_run("number of outputs differs from the number of accepted samples");
      end
   endtask

   task automatic test_clear_offset();
      drive_cycle(op_set_freq, nba'(32'h000b_3f21), 1'b0, '0);
      for (int k = 0; k < 60; k++) begin
         case (k)
            15:      drive_cycle(op_clear, '0, 1'b1, SW'($random(seed)));
            30:      drive_cycle(op_set_phase, nba'($random(seed)), 1'b1, SW'($random(seed)));
            45:      drive_cycle(op_clear, '0, 1'b0, '0);      // clear on an idle cycle
            default: drive_cycle(op_nop, '0, 1'b1, SW'($random(seed)));
         endcase
      end
      wait_drain();
   endtask

   initial begin : main
      c         = 1'b0;
      rst_n     = 1'b0;
      ctl_op    = op_nop;
      ctl_data  = '0;
      in_valid  = 1'b0;
      in_sample = '0;
      seed      = 32'hc941_12ae;
      cyc       = 0;
      n_in      = 0;
      n_out     = 0;
      m_freq    = '0;
      m_phase   = '0;
      m_acc     = '0;
      repeat (16) @(negedge c);
      rst_n = 1'b1;
      test_reset_idle();
      test_fixed_phase();
      test_sweep();
      test_gapped();
      test_clear_offset();
      if (exp_cyc_q.size() == 0 && n_out == n_in) begin
         $display("Simulation finished: PASS");
         $finish;
      end else begin
         abort_run("outputs left outstanding at the end of the run");
      end
   end

endmodule

`default_nettype wire

/* sources.f */
verilog/nco_pkg.sv
verilog/ddc_pkg.sv
verilog/mix_if.sv
verilog/phase_accum.sv
verilog/cos_table_rom.sv
verilog/cosine_int.sv
verilog/quad_mixer.sv
verilog/ddc_top.sv
tests/ddc_chk.sv
tests/ddc_tb.sv
